/* verilog/ray_fixed_pkg.sv */
package ray_fixed_pkg;

	// fixed-point format shared by the whole lighting pipeline
	// every coordinate, normal component and distance is a signed word
	// with a fixed number of fraction bits

	// default signed word width
	localparam int DEF_BUS_WIDTH = 24;

	// default fraction bits, so 1.0 is 1 << 12
	localparam int DEF_FRAC_WIDTH = 12;

	// squares and the squared length use a double word with twice the fraction bits
	// the square root of such a value lands back on DEF_FRAC_WIDTH fraction bits

	// enabled cycles through the geometry front end
	// light vector, then products and squares, then the two sums
	localparam int GEOM_STAGES = 3;

	// registers behind the divider in the shading stage
	// clamp, scaling and colour select sit in front of these
	localparam int SHADE_EXTRA_STAGES = 1;

	// root and divider depth is not kept here
	// both resolve two result bits per stage, so each block works out
	// BUS_WIDTH/2 stages from its own width parameter

	// total latency with the defaults
	// GEOM_STAGES + 12 root + 12 divide + SHADE_EXTRA_STAGES = 28

endpackage

/* verilog/ray_pixel_pkg.sv */
package ray_pixel_pkg;

	// per-pixel types that travel alongside the lighting math

	// screen coordinate, 512 columns or rows at most
	typedef logic [8:0] coord_t;

	// rgb444 colour
	// red in [11:8], green in [7:4], blue in [3:0]
	typedef logic [11:0] color_t;

	// metadata that rides with every item through the pipeline
	// nothing in here takes part in the arithmetic, except that the colour
	// feeds the final scaling and use_shading picks the output
	typedef struct packed {
		// pixel position the ray belongs to
		coord_t pixel_x;
		coord_t pixel_y;
		// marks a real hit, the pipeline itself carries no valid bit
		logic ray_hit;
		// surface colour before lighting
		color_t color;
		// high selects the diffuse result, low passes the colour through
		logic use_shading;
	} pix_meta_t;

	// width of the struct with the default field sizes
	// 9 + 9 + 1 + 12 + 1 = 32 bits

	// the hit distance t is not in here
	// it is a signed fixed-point word and its width follows BUS_WIDTH

endpackage

/* verilog/geom_if.sv */
`timescale 1ns/1ns

interface geom_if
	import ray_fixed_pkg::*, ray_pixel_pkg::*;
#(
	parameter int BUS_WIDTH = DEF_BUS_WIDTH
);

	// dot product of the light vector with the normal, same format as the inputs
	logic signed [BUS_WIDTH-1:0] dot;

	// squared length of the light vector
	// double width with twice the fraction bits, always positive
	logic [2*BUS_WIDTH-1:0] sum_sq;

	// pixel data of the item that produced these results
	pix_meta_t meta;

	// hit distance, carried along untouched
	logic signed [BUS_WIDTH-1:0] t;

	// geometry stage drives everything
	modport src (output dot, output sum_sq, output meta, output t);

	// square root only needs the squared length
	modport root (input sum_sq);

	// delay lines running next to the root take the rest
	modport side (input dot, input meta, input t);

endinterface

/* verilog/stage_delay.sv */
`timescale 1ns/1ns

module stage_delay
#(
	parameter type DATA_T = logic,
	parameter int DEPTH = 1
)
(
	input logic clk,
	input logic rst_n,
	input logic clken,
	input DATA_T din,
	output DATA_T dout
);

	// one slot per enabled cycle of delay
	DATA_T pipe [DEPTH];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				pipe[i] <= '0;
			end
		end
		else if (clken)
		begin
			pipe[0] <= din;
			// whole line moves together, holds while clken is low
			for (int i = 1; i < DEPTH; i++)
			begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign dout = pipe[DEPTH-1];

endmodule

/* verilog/light_geom.sv */
`timescale 1ns/1ns

module light_geom
	import ray_fixed_pkg::*, ray_pixel_pkg::*;
#(
	parameter int BUS_WIDTH = DEF_BUS_WIDTH,
	parameter int FRAC_WIDTH = DEF_FRAC_WIDTH
)
(
	input logic clk,
	input logic rst_n,
	input logic clken,
	input logic signed [BUS_WIDTH-1:0] lx,
	input logic signed [BUS_WIDTH-1:0] ly,
	input logic signed [BUS_WIDTH-1:0] lz,
	input logic signed [BUS_WIDTH-1:0] inter_x,
	input logic signed [BUS_WIDTH-1:0] inter_y,
	input logic signed [BUS_WIDTH-1:0] inter_z,
	input logic signed [BUS_WIDTH-1:0] nx,
	input logic signed [BUS_WIDTH-1:0] ny,
	input logic signed [BUS_WIDTH-1:0] nz,
	input pix_meta_t meta_in,
	input logic signed [BUS_WIDTH-1:0] t_in,
	geom_if.src geo
);

	// stage 1: light vector and the normal held next to it
	logic signed [BUS_WIDTH-1:0] lv_x, lv_y, lv_z;
	logic signed [BUS_WIDTH-1:0] n_x, n_y, n_z;

	// stage 2: rescaled products with the normal, raw squares
	logic signed [BUS_WIDTH-1:0] dp_x, dp_y, dp_z;
	logic [2*BUS_WIDTH-1:0] sq_x, sq_y, sq_z;

	// stage 3: the two sums
	logic signed [BUS_WIDTH-1:0] dot_q;
	logic [2*BUS_WIDTH-1:0] sum_sq_q;

	// full width multiplier outputs
	logic signed [2*BUS_WIDTH-1:0] mul_x, mul_y, mul_z;
	logic signed [2*BUS_WIDTH-1:0] sqf_x, sqf_y, sqf_z;

	// pixel data and distance, one slot per geometry stage
	pix_meta_t meta_q [GEOM_STAGES];
	logic signed [BUS_WIDTH-1:0] t_q [GEOM_STAGES];

	// products carry 2*FRAC_WIDTH fraction bits
	assign mul_x = lv_x * n_x;
	assign mul_y = lv_y * n_y;
	assign mul_z = lv_z * n_z;

	// squares keep the double format, the root brings them back
	assign sqf_x = lv_x * lv_x;
	assign sqf_y = lv_y * lv_y;
	assign sqf_z = lv_z * lv_z;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lv_x <= '0;
			lv_y <= '0;
			lv_z <= '0;
			n_x <= '0;
			n_y <= '0;
			n_z <= '0;
			dp_x <= '0;
			dp_y <= '0;
			dp_z <= '0;
			sq_x <= '0;
			sq_y <= '0;
			sq_z <= '0;
			dot_q <= '0;
			sum_sq_q <= '0;
		end
		else if (clken)
		begin
			// L = light - intersection
			lv_x <= lx - inter_x;
			lv_y <= ly - inter_y;
			lv_z <= lz - inter_z;
			n_x <= nx;
			n_y <= ny;
			n_z <= nz;
			// drop FRAC_WIDTH fraction bits to get back to one word
			dp_x <= mul_x[BUS_WIDTH+FRAC_WIDTH-1:FRAC_WIDTH];
			dp_y <= mul_y[BUS_WIDTH+FRAC_WIDTH-1:FRAC_WIDTH];
			dp_z <= mul_z[BUS_WIDTH+FRAC_WIDTH-1:FRAC_WIDTH];
			sq_x <= sqf_x;
			sq_y <= sqf_y;
			sq_z <= sqf_z;
			dot_q <= dp_x + dp_y + dp_z;
			// three squares of a signed word never overflow the double word
			sum_sq_q <= sq_x + sq_y + sq_z;
		end
	end

	// side data shifts in step with the arithmetic
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < GEOM_STAGES; i++)
			begin
				meta_q[i] <= '0;
				t_q[i] <= '0;
			end
		end
		else if (clken)
		begin
			meta_q[0] <= meta_in;
			t_q[0] <= t_in;
			for (int i = 1; i < GEOM_STAGES; i++)
			begin
				meta_q[i] <= meta_q[i-1];
				t_q[i] <= t_q[i-1];
			end
		end
	end

	assign geo.dot = dot_q;
	assign geo.sum_sq = sum_sq_q;
	assign geo.meta = meta_q[GEOM_STAGES-1];
	assign geo.t = t_q[GEOM_STAGES-1];

endmodule

/* verilog/mag_sqrt.sv */
`timescale 1ns/1ns

module mag_sqrt
	import ray_fixed_pkg::*;
#(
	parameter int BUS_WIDTH = DEF_BUS_WIDTH
)
(
	input logic clk,
	input logic rst_n,
	input logic clken,
	geom_if.root geo,
	output logic signed [BUS_WIDTH-1:0] mag
);

	// two root bits per stage, BUS_WIDTH root bits in total
	localparam int STAGES = BUS_WIDTH / 2;
	// partial remainder may go negative, a few spare bits above the root
	localparam int REM_W = BUS_WIDTH + 4;

	// what each stage starts from
	logic signed [REM_W-1:0] rem_in [STAGES];
	logic [BUS_WIDTH-1:0] root_in [STAGES];
	logic [2*BUS_WIDTH-1:0] rad_in [STAGES];

	// what each stage produces
	logic signed [REM_W-1:0] rem_d [STAGES];
	logic [BUS_WIDTH-1:0] root_d [STAGES];

	// stage registers
	logic signed [REM_W-1:0] rem_q [STAGES];
	logic [BUS_WIDTH-1:0] root_q [STAGES];
	logic [2*BUS_WIDTH-1:0] rad_q [STAGES];

	// one non-restoring step, returns {remainder, root}
	function automatic logic [REM_W+BUS_WIDTH-1:0] sqrt_iter(
		input logic signed [REM_W-1:0] rem,
		input logic [BUS_WIDTH-1:0] root,
		input logic [1:0] digits
	);
		logic signed [REM_W-1:0] shifted;
		logic signed [REM_W-1:0] rem_next;
		shifted = (rem <<< 2) + {{(REM_W-2){1'b0}}, digits};
		// positive remainder subtracts 4q+1, negative adds 4q+3
		if (!rem[REM_W-1])
			rem_next = shifted - {2'b00, root, 2'b01};
		else
			rem_next = shifted + {2'b00, root, 2'b11};
		return {rem_next, root[BUS_WIDTH-2:0], ~rem_next[REM_W-1]};
	endfunction

	// first stage takes the fresh radicand, the others their predecessor
	always_comb
	begin
		rem_in[0] = '0;
		root_in[0] = '0;
		rad_in[0] = geo.sum_sq;
		for (int s = 1; s < STAGES; s++)
		begin
			rem_in[s] = rem_q[s-1];
			root_in[s] = root_q[s-1];
			rad_in[s] = rad_q[s-1];
		end
	end

	always_comb
	begin
		logic [REM_W+BUS_WIDTH-1:0] step;
		for (int s = 0; s < STAGES; s++)
		begin
			// top two radicand bits, then the next two
			step = sqrt_iter(rem_in[s], root_in[s], rad_in[s][2*BUS_WIDTH-1 -: 2]);
			step = sqrt_iter(step[REM_W+BUS_WIDTH-1:BUS_WIDTH], step[BUS_WIDTH-1:0],
				rad_in[s][2*BUS_WIDTH-3 -: 2]);
			rem_d[s] = step[REM_W+BUS_WIDTH-1:BUS_WIDTH];
			root_d[s] = step[BUS_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < STAGES; s++)
			begin
				rem_q[s] <= '0;
				root_q[s] <= '0;
				rad_q[s] <= '0;
			end
		end
		else if (clken)
		begin
			for (int s = 0; s < STAGES; s++)
			begin
				rem_q[s] <= rem_d[s];
				root_q[s] <= root_d[s];
				// four radicand bits used up per stage
				rad_q[s] <= rad_in[s] << 4;
			end
		end
	end

	// floor of the root, the remainder needs no correction for that
	assign mag = root_q[STAGES-1];

endmodule

/* verilog/diffuse_shade.sv */
`timescale 1ns/1ns

module diffuse_shade
	import ray_fixed_pkg::*, ray_pixel_pkg::*;
#(
	parameter int BUS_WIDTH = DEF_BUS_WIDTH,
	parameter int FRAC_WIDTH = DEF_FRAC_WIDTH
)
(
	input logic clk,
	input logic rst_n,
	input logic clken,
	input logic signed [BUS_WIDTH-1:0] mag,
	input logic signed [BUS_WIDTH-1:0] dot,
	input pix_meta_t meta_in,
	input logic signed [BUS_WIDTH-1:0] t_in,
	output color_t light,
	output pix_meta_t meta_out,
	output logic signed [BUS_WIDTH-1:0] t_out
);

	// two quotient bits per stage
	localparam int STAGES = BUS_WIDTH / 2;

	typedef struct packed {
		pix_meta_t meta;
		logic signed [BUS_WIDTH-1:0] t;
	} side_t;

	typedef struct packed {
		color_t light;
		side_t side;
	} out_t;

	// dot sign, zero divisor, quotient wider than BUS_WIDTH
	typedef struct packed {
		logic neg;
		logic zero;
		logic ovf;
	} flag_t;

	// divider works on magnitudes, sign kept in the flags
	logic [BUS_WIDTH-1:0] abs_dot;
	logic [BUS_WIDTH-1:0] rem_in [STAGES], quo_in [STAGES];
	logic [BUS_WIDTH-1:0] low_in [STAGES], den_in [STAGES];
	flag_t flag_in [STAGES];
	logic [BUS_WIDTH-1:0] rem_d [STAGES], quo_d [STAGES];
	logic [BUS_WIDTH-1:0] rem_q [STAGES], quo_q [STAGES];
	logic [BUS_WIDTH-1:0] low_q [STAGES], den_q [STAGES];
	flag_t flag_q [STAGES];

	side_t side_in, side_dly;
	logic [BUS_WIDTH-1:0] q_eff;
	logic lit;
	color_t shaded, light_d;
	out_t out_q [SHADE_EXTRA_STAGES];

	// restoring step, returns {remainder, quotient bit}
	function automatic logic [BUS_WIDTH:0] div_iter(
		input logic [BUS_WIDTH-1:0] rem,
		input logic bit_in,
		input logic [BUS_WIDTH-1:0] den
	);
		logic [BUS_WIDTH:0] trial;
		trial = {rem, bit_in};
		if (trial >= {1'b0, den})
			return {trial[BUS_WIDTH-1:0] - den, 1'b1};
		return {trial[BUS_WIDTH-1:0], 1'b0};
	endfunction

	// q * nibble back to a nibble, saturating at 15
	function automatic logic [3:0] scale_nib(
		input logic [BUS_WIDTH-1:0] q,
		input logic [3:0] nib
	);
		logic [BUS_WIDTH+3:0] prod;
		prod = q * nib;
		if (|prod[BUS_WIDTH+3:FRAC_WIDTH+4])
			return 4'hf;
		return prod[FRAC_WIDTH+3:FRAC_WIDTH];
	endfunction

	assign abs_dot = dot[BUS_WIDTH-1] ? -dot : dot;

	always_comb
	begin
		// numerator is |dot| << FRAC_WIDTH, its top FRAC_WIDTH bits seed the remainder
		rem_in[0] = {{(BUS_WIDTH-FRAC_WIDTH){1'b0}}, abs_dot[BUS_WIDTH-1 -: FRAC_WIDTH]};
		low_in[0] = {abs_dot[BUS_WIDTH-FRAC_WIDTH-1:0], {FRAC_WIDTH{1'b0}}};
		quo_in[0] = '0;
		den_in[0] = mag;
		flag_in[0].neg = dot[BUS_WIDTH-1];
		flag_in[0].zero = (mag == '0);
		// seed not below the divisor means the quotient needs more than BUS_WIDTH bits
		flag_in[0].ovf = (rem_in[0] >= den_in[0]);
		for (int s = 1; s < STAGES; s++)
		begin
			rem_in[s] = rem_q[s-1];
			quo_in[s] = quo_q[s-1];
			low_in[s] = low_q[s-1];
			den_in[s] = den_q[s-1];
			flag_in[s] = flag_q[s-1];
		end
	end

	always_comb
	begin
		logic [BUS_WIDTH:0] hi_step;
		logic [BUS_WIDTH:0] lo_step;
		for (int s = 0; s < STAGES; s++)
		begin
			hi_step = div_iter(rem_in[s], low_in[s][BUS_WIDTH-1], den_in[s]);
			lo_step = div_iter(hi_step[BUS_WIDTH:1], low_in[s][BUS_WIDTH-2], den_in[s]);
			rem_d[s] = lo_step[BUS_WIDTH:1];
			quo_d[s] = {quo_in[s][BUS_WIDTH-3:0], hi_step[0], lo_step[0]};
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < STAGES; s++)
			begin
				rem_q[s] <= '0;
				quo_q[s] <= '0;
				low_q[s] <= '0;
				den_q[s] <= '0;
				flag_q[s] <= '0;
			end
		end
		else if (clken)
		begin
			for (int s = 0; s < STAGES; s++)
			begin
				rem_q[s] <= rem_d[s];
				quo_q[s] <= quo_d[s];
				low_q[s] <= low_in[s] << 2;
				den_q[s] <= den_in[s];
				flag_q[s] <= flag_in[s];
			end
		end
	end

	// pixel data waits out the divider
	assign side_in = '{meta: meta_in, t: t_in};

	stage_delay #(
		.DATA_T(side_t),
		.DEPTH(STAGES)
	) u_side_dly (
		.clk(clk),
		.rst_n(rst_n),
		.clken(clken),
		.din(side_in),
		.dout(side_dly)
	);

	// an overflowed quotient saturates every lit channel anyway
	assign q_eff = flag_q[STAGES-1].ovf ? '1 : quo_q[STAGES-1];
	// zero divisor, back face or a quotient of zero all give black
	assign lit = !flag_q[STAGES-1].neg && !flag_q[STAGES-1].zero && (q_eff != '0);
	assign shaded = lit ? {scale_nib(q_eff, side_dly.meta.color[11:8]),
		scale_nib(q_eff, side_dly.meta.color[7:4]),
		scale_nib(q_eff, side_dly.meta.color[3:0])} : '0;
	assign light_d = side_dly.meta.use_shading ? shaded : side_dly.meta.color;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < SHADE_EXTRA_STAGES; i++)
			begin
				out_q[i] <= '0;
			end
		end
		else if (clken)
		begin
			out_q[0] <= '{light: light_d, side: side_dly};
			for (int i = 1; i < SHADE_EXTRA_STAGES; i++)
			begin
				out_q[i] <= out_q[i-1];
			end
		end
	end

	assign light = out_q[SHADE_EXTRA_STAGES-1].light;
	assign meta_out = out_q[SHADE_EXTRA_STAGES-1].side.meta;
	assign t_out = out_q[SHADE_EXTRA_STAGES-1].side.t;

endmodule

/* verilog/ray_lighting_top.sv */
`timescale 1ns/1ns

module ray_lighting_top
	import ray_fixed_pkg::*, ray_pixel_pkg::*;
#(
	parameter int BUS_WIDTH = DEF_BUS_WIDTH,
	parameter int FRAC_WIDTH = DEF_FRAC_WIDTH
)
(
	input logic clk,
	input logic rst_n,
	input logic clken,
	input logic signed [BUS_WIDTH-1:0] lx,
	input logic signed [BUS_WIDTH-1:0] ly,
	input logic signed [BUS_WIDTH-1:0] lz,
	input logic signed [BUS_WIDTH-1:0] inter_x,
	input logic signed [BUS_WIDTH-1:0] inter_y,
	input logic signed [BUS_WIDTH-1:0] inter_z,
	input logic signed [BUS_WIDTH-1:0] nx,
	input logic signed [BUS_WIDTH-1:0] ny,
	input logic signed [BUS_WIDTH-1:0] nz,
	input color_t color,
	input coord_t pixel_x,
	input coord_t pixel_y,
	input logic ray_hit,
	input logic use_shading,
	input logic signed [BUS_WIDTH-1:0] t,
	output color_t light,
	output coord_t pixel_x_out,
	output coord_t pixel_y_out,
	output logic ray_hit_out,
	output logic signed [BUS_WIDTH-1:0] t_out
);

	// side delay must match the root pipeline depth
	localparam int ROOT_STAGES = BUS_WIDTH / 2;

	typedef logic signed [BUS_WIDTH-1:0] word_t;

	pix_meta_t meta_in;
	pix_meta_t meta_side;
	pix_meta_t meta_out;
	word_t dot_side;
	word_t t_side;
	logic signed [BUS_WIDTH-1:0] mag;

	geom_if #(.BUS_WIDTH(BUS_WIDTH)) geo_bus ();

	assign meta_in = '{pixel_x: pixel_x, pixel_y: pixel_y, ray_hit: ray_hit,
		color: color, use_shading: use_shading};

	light_geom #(.BUS_WIDTH(BUS_WIDTH), .FRAC_WIDTH(FRAC_WIDTH)) u_geom (
		.clk(clk), .rst_n(rst_n), .clken(clken),
		.lx(lx), .ly(ly), .lz(lz),
		.inter_x(inter_x), .inter_y(inter_y), .inter_z(inter_z),
		.nx(nx), .ny(ny), .nz(nz),
		.meta_in(meta_in), .t_in(t), .geo(geo_bus)
	);

	mag_sqrt #(.BUS_WIDTH(BUS_WIDTH)) u_sqrt (
		.clk(clk), .rst_n(rst_n), .clken(clken), .geo(geo_bus), .mag(mag)
	);

	// dot, metadata and distance wait next to the root
	stage_delay #(.DATA_T(word_t), .DEPTH(ROOT_STAGES)) u_dot_dly (
		.clk(clk), .rst_n(rst_n), .clken(clken), .din(geo_bus.dot), .dout(dot_side)
	);

	stage_delay #(.DATA_T(word_t), .DEPTH(ROOT_STAGES)) u_t_dly (
		.clk(clk), .rst_n(rst_n), .clken(clken), .din(geo_bus.t), .dout(t_side)
	);

	stage_delay #(.DATA_T(pix_meta_t), .DEPTH(ROOT_STAGES)) u_meta_dly (
		.clk(clk), .rst_n(rst_n), .clken(clken), .din(geo_bus.meta), .dout(meta_side)
	);

	diffuse_shade #(.BUS_WIDTH(BUS_WIDTH), .FRAC_WIDTH(FRAC_WIDTH)) u_shade (
		.clk(clk), .rst_n(rst_n), .clken(clken),
		.mag(mag), .dot(dot_side), .meta_in(meta_side), .t_in(t_side),
		.light(light), .meta_out(meta_out), .t_out(t_out)
	);

	assign pixel_x_out = meta_out.pixel_x;
	assign pixel_y_out = meta_out.pixel_y;
	assign ray_hit_out = meta_out.ray_hit;

endmodule

/* dv/ray_lighting_asserts.sv */
`timescale 1ns/1ns

module ray_lighting_asserts
	import ray_fixed_pkg::*, ray_pixel_pkg::*;
#(
	parameter int BUS_WIDTH = DEF_BUS_WIDTH
)
(
	input logic clk,
	input logic rst_n,
	input logic clken,
	input color_t light,
	input coord_t pixel_x_out,
	input coord_t pixel_y_out,
	input logic ray_hit_out,
	input logic signed [BUS_WIDTH-1:0] t_out,
	input pix_meta_t meta_out
);

	// failed assertions so far, watched by the testbench
	int fail_count = 0;

	// a stalled edge must not move any output
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!clken |=> $stable(light) && $stable(pixel_x_out) && $stable(pixel_y_out)
			&& $stable(ray_hit_out) && $stable(t_out))
	else
	begin
		fail_count++;
		$error("outputs changed across an edge with clken low");
	end

	// first edge out of reset still shows the cleared pipeline
	hit_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !ray_hit_out)
	else
	begin
		fail_count++;
		$error("ray_hit_out high right after reset");
	end

	// flat items pass their colour through
	flat_color_pass: assert property (@(posedge clk) disable iff (!rst_n)
		!meta_out.use_shading |-> light == meta_out.color)
	else
	begin
		fail_count++;
		$error("light differs from colour with shading off");
	end

endmodule

bind ray_lighting_top ray_lighting_asserts #(.BUS_WIDTH(BUS_WIDTH)) u_asserts (
	.clk(clk), .rst_n(rst_n), .clken(clken), .light(light),
	.pixel_x_out(pixel_x_out), .pixel_y_out(pixel_y_out), .ray_hit_out(ray_hit_out),
	.t_out(t_out), .meta_out(meta_out)
);

/* dv/ray_lighting_tb.sv */
`timescale 1ns/1ns

module ray_lighting_tb
	import ray_fixed_pkg::*, ray_pixel_pkg::*;
;

	localparam int BUS_WIDTH = DEF_BUS_WIDTH;
	// 1.0 in the default fixed-point format
	localparam int ONE = 1 << DEF_FRAC_WIDTH;
	// enabled edges from input sample to output
	localparam int LATENCY = 28;
	localparam int NROWS = 10;
	localparam int MAX_CYCLES = 2000;

	typedef logic signed [BUS_WIDTH-1:0] word_t;

	// one stimulus row and the light value the shading rule gives for it
	typedef struct {
		string name;
		word_t lx, ly, lz;
		word_t ix, iy, iz;
		word_t nx, ny, nz;
		color_t color;
		logic use_shading;
		color_t exp_light;
		coord_t px, py;
		logic hit;
		word_t t;
	} row_t;

	// an item in flight: its row and the enabled edge after which it shows up
	typedef struct {
		int row;
		int due;
	} pend_t;

	logic clk = 1'b0;
	logic rst_n;
	logic clken;
	word_t lx, ly, lz, inter_x, inter_y, inter_z, nx, ny, nz, t;
	color_t color;
	coord_t pixel_x, pixel_y;
	logic ray_hit, use_shading;
	color_t light;
	coord_t pixel_x_out, pixel_y_out;
	logic ray_hit_out;
	word_t t_out;

	row_t rows [NROWS];
	pend_t exp_q [$];

	ray_lighting_top dut0 (.*);

	always #20 clk = ~clk;

	// the bound checker counts its failures, the first one ends the run
	always @(dut0.u_asserts.fail_count)
	begin
		if (dut0.u_asserts.fail_count != 0)
		begin
			$display("a bound assertion on the DUT outputs failed");
			$display("TEST FAILED");
			$fatal(1, "assertion failure");
		end
	end

	task automatic check_value(string name, logic [31:0] exp_v, logic [31:0] act_v);
		if (exp_v !== act_v)
		begin
			$display("FAILED %s expected %0h actual %0h", name, exp_v, act_v);
			$display("TEST FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	// geometry and colour come from the caller, pixel data is random
	function automatic row_t make_row(string name, int lx_v, int ly_v, int lz_v,
		int ix_v, int iy_v, int iz_v, int nx_v, int ny_v, int nz_v,
		color_t col, logic shade, color_t exp_col);
		row_t r;
		r.name = name;
		r.lx = lx_v;
		r.ly = ly_v;
		r.lz = lz_v;
		r.ix = ix_v;
		r.iy = iy_v;
		r.iz = iz_v;
		r.nx = nx_v;
		r.ny = ny_v;
		r.nz = nz_v;
		r.color = col;
		r.use_shading = shade;
		r.exp_light = exp_col;
		r.px = coord_t'($urandom_range(511));
		r.py = coord_t'($urandom_range(511));
		r.hit = $urandom_range(1);
		r.t = word_t'($urandom);
		return r;
	endfunction

	task automatic load_table();
		// q = 1.0, channels unchanged
		rows[0] = make_row("along_normal", 0, 0, 2*ONE, 0, 0, 0, 0, 0, ONE, 12'hA5F, 1, 12'hA5F);
		rows[1] = make_row("full_scale", 0, 0, 2*ONE, 0, 0, 0, 0, 0, ONE, 12'hFFF, 1, 12'hFFF);
		// normal of length 2 gives q = 2.0, blue saturates
		rows[2] = make_row("long_normal", 0, 0, 2*ONE, 0, 0, 0, 0, 0, 2*ONE,
			12'h37C, 1, 12'h6EF);
		// L = (3,0,4), |L| = 5, q = 3276
		rows[3] = make_row("oblique_345", 3*ONE, 0, 4*ONE, 0, 0, 0, 0, 0, ONE,
			12'h8F4, 1, 12'h6B3);
		// L = (1,1,1), |L| floors to 7094, q = 2364
		rows[4] = make_row("oblique_diag", 5*ONE, 2*ONE, ONE, 4*ONE, ONE, 0, 0, 0, ONE,
			12'hC6F, 1, 12'h638);
		rows[5] = make_row("back_facing", 0, 0, 2*ONE, 0, 0, 0, 0, 0, -ONE, 12'hFFF, 1, 12'h000);
		// dot product exactly zero
		rows[6] = make_row("grazing", 0, 0, 2*ONE, 0, 0, 0, ONE, 0, 0, 12'hFFF, 1, 12'h000);
		// light on the hit point, mag is zero
		rows[7] = make_row("light_on_hit", 1000, 2000, 3000, 1000, 2000, 3000, 0, 0, ONE,
			12'hFFF, 1, 12'h000);
		// flat colour passes through even when back facing
		rows[8] = make_row("flat_back", 0, 0, 2*ONE, 0, 0, 0, 0, 0, -ONE, 12'h9A3, 0, 12'h9A3);
		rows[9] = make_row("flat_lit", 0, 0, 2*ONE, 0, 0, 0, 0, 0, ONE, 12'h123, 0, 12'h123);
	endtask

	task automatic apply_row(int r);
		lx <= rows[r].lx;
		ly <= rows[r].ly;
		lz <= rows[r].lz;
		inter_x <= rows[r].ix;
		inter_y <= rows[r].iy;
		inter_z <= rows[r].iz;
		nx <= rows[r].nx;
		ny <= rows[r].ny;
		nz <= rows[r].nz;
		color <= rows[r].color;
		use_shading <= rows[r].use_shading;
		pixel_x <= rows[r].px;
		pixel_y <= rows[r].py;
		ray_hit <= rows[r].hit;
		t <= rows[r].t;
	endtask

	task automatic check_outputs(int r);
		check_value($sformatf("%s/light", rows[r].name), rows[r].exp_light, light);
		check_value($sformatf("%s/pixel_x", rows[r].name), rows[r].px, pixel_x_out);
		check_value($sformatf("%s/pixel_y", rows[r].name), rows[r].py, pixel_y_out);
		check_value($sformatf("%s/ray_hit", rows[r].name), rows[r].hit, ray_hit_out);
		check_value($sformatf("%s/t", rows[r].name), rows[r].t, t_out);
	endtask

	initial
	begin
		int enabled;
		int cycles;
		int next_item;
		int pending;
		int seen;
		pend_t head;
		void'($urandom(84738));
		load_table();
		{lx, ly, lz, inter_x, inter_y, inter_z, nx, ny, nz, t} = '0;
		color = '0;
		pixel_x = '0;
		pixel_y = '0;
		ray_hit = 1'b0;
		use_shading = 1'b0;
		clken = 1'b0;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		clken <= 1'b1;
		enabled = 0;
		cycles = 0;
		next_item = 0;
		pending = -1;
		seen = 0;
		// first pass runs without stalls, the second with a random clken
		while (next_item < 2*NROWS || pending >= 0 || exp_q.size() != 0)
		begin
			if (cycles == MAX_CYCLES)
			begin
				$display("timeout waiting for %0d items still in the pipeline", exp_q.size());
				$display("TEST FAILED");
				$fatal(1, "pipeline drain timed out");
			end
			@(posedge clk);
			cycles++;
			// inputs were sampled on this edge only if clken was high
			if (clken)
			begin
				enabled++;
				if (pending >= 0)
					exp_q.push_back('{row: pending, due: enabled + LATENCY - 1});
				pending = -1;
				if (next_item < 2*NROWS)
				begin
					pending = next_item % NROWS;
					apply_row(pending);
					next_item++;
				end
			end
			if (next_item >= NROWS)
				clken <= ($urandom_range(3) != 0);
			else
				clken <= 1'b1;
			// outputs are settled by the falling edge
			@(negedge clk);
			if (exp_q.size() != 0 && exp_q[0].due == enabled)
			begin
				head = exp_q.pop_front();
				check_outputs(head.row);
				seen++;
			end
			else if (seen == 0)
			begin
				// only reset values until the first row comes out
				check_value("reset/light", 0, light);
				check_value("reset/pixel_x", 0, pixel_x_out);
				check_value("reset/pixel_y", 0, pixel_y_out);
				check_value("reset/ray_hit", 0, ray_hit_out);
				check_value("reset/t", 0, t_out);
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* build.f */
verilog/ray_fixed_pkg.sv
verilog/ray_pixel_pkg.sv
verilog/geom_if.sv
verilog/stage_delay.sv
verilog/light_geom.sv
verilog/mag_sqrt.sv
verilog/diffuse_shade.sv
verilog/ray_lighting_top.sv
dv/ray_lighting_asserts.sv
dv/ray_lighting_tb.sv

/* Bender.yml */
package:
  name: ray_lighting

sources:
  # packages first, then the interface and the blocks
  - verilog/ray_fixed_pkg.sv
  - verilog/ray_pixel_pkg.sv
  - verilog/geom_if.sv
  - verilog/stage_delay.sv
  - verilog/light_geom.sv
  - verilog/mag_sqrt.sv
  - verilog/diffuse_shade.sv
  - verilog/ray_lighting_top.sv
  # testbench sources
  - target: simulation
    files:
      - dv/ray_lighting_asserts.sv
      - dv/ray_lighting_tb.sv
